// ==== axi_lite_pkg.sv ====
package axi_lite_pkg;

  // read channel widths, lite subset only
  localparam int unsigned AXI_ADDR_WIDTH = 64;
  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned AXI_RESP_WIDTH = 2;

  // arprot bits: [0] privileged, [1] non-secure, [2] instruction
  localparam logic [2:0] AXI_PROT_FETCH = 3'b101;  // privileged secure instr

  // arsize encodes log2 of the bytes per beat
  localparam logic [2:0] AXI_SIZE_DWORD = 3'b011;  // 8 bytes

endpackage

// ==== rv_pkg.sv ====
package rv_pkg;

  localparam int unsigned XLEN          = 64;
  localparam int unsigned ILEN          = 32;
  localparam int unsigned REG_IDX_WIDTH = 5;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  // opcodes that carry an I-type immediate
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // addi, slti, ...
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // one instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [6:0]               funct7;
      logic [REG_IDX_WIDTH-1:0] rs2;
      logic [REG_IDX_WIDTH-1:0] rs1;
      logic [2:0]               funct3;
      logic [REG_IDX_WIDTH-1:0] rd;
      logic [6:0]               opcode;
    } r;
    struct packed {
      logic [11:0]              imm;  // bits 31:20
      logic [REG_IDX_WIDTH-1:0] rs1;
      logic [2:0]               funct3;
      logic [REG_IDX_WIDTH-1:0] rd;
      logic [6:0]               opcode;
    } i;
  } rv_instr_u;

endpackage

// ==== pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n_i,

  // redirect from outside
  input  logic            jump_i,
  input  logic [XLEN-1:0] jump_pc_i,

  // from the fetch master, one per accepted AR
  input  logic            pc_step_i,

  output logic [XLEN-1:0] fetch_pc_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_seq;

  // next sequential address, 32-bit instructions only
  assign pc_seq = pc_q + XLEN'(4);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= RESET_PC;
    end else if (jump_i) begin
      pc_q <= jump_pc_i;   // jump wins over step
    end else if (pc_step_i) begin
      pc_q <= pc_seq;
    end
  end

  assign fetch_pc_o = pc_q;

endmodule

// ==== axi_fetch_master.sv ====
`timescale 1ns/1ps

module axi_fetch_master import axi_lite_pkg::*, rv_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n_i,

  input  logic                      stall_n_i,   // low holds the front end
  input  logic                      jump_i,

  // program counter side
  input  logic [XLEN-1:0]           fetch_pc_i,
  output logic                      pc_step_o,

  // AR channel
  input  logic                      ar_ready_i,
  output logic                      ar_valid_o,
  output logic [AXI_ADDR_WIDTH-1:0] ar_addr_o,
  output logic [2:0]                ar_prot_o,
  output logic [2:0]                ar_size_o,

  // R channel
  input  logic                      r_valid_i,
  output logic                      r_ready_o,
  input  logic [AXI_DATA_WIDTH-1:0] r_data_i,
  input  logic [AXI_RESP_WIDTH-1:0] r_resp_i,    // not checked, no trap path

  // to decode
  output logic                      fetch_valid_o,
  output logic [XLEN-1:0]           fetch_pc_o,
  output logic [ILEN-1:0]           fetch_instr_o
);

  // idle when neither phase is pending
  logic            ar_pend_q;
  logic            r_pend_q;
  logic            stale_q;      // outstanding read belongs to a pre-jump PC
  logic            valid_q;
  logic [XLEN-1:0] req_pc_q;     // PC of the read in flight
  logic            idle;
  logic            issue;
  logic            ar_hs;
  logic            r_hs;
  logic [ILEN-1:0] instr_sel;

  assign idle  = !ar_pend_q && !r_pend_q;
  assign issue = idle && stall_n_i;
  assign ar_hs = ar_pend_q && ar_ready_i;
  assign r_hs  = r_ready_o && r_valid_i;

  // PC bit 2 picks the half of the 64-bit beat
  assign instr_sel = req_pc_q[2] ? r_data_i[63:32] : r_data_i[31:0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_pend_q <= 1'b0;
      r_pend_q  <= 1'b0;
      stale_q   <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= r_hs && !stale_q && !jump_i;

      if (issue) begin
        ar_pend_q <= 1'b1;
        stale_q   <= jump_i;       // address taken before the redirect lands
      end else if (jump_i && !idle) begin
        stale_q   <= 1'b1;
      end

      if (ar_hs) begin
        ar_pend_q <= 1'b0;
        r_pend_q  <= 1'b1;
      end

      if (r_hs) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // request PC, held while the read is in flight
  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc_q <= fetch_pc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (r_hs) begin
      fetch_pc_o    <= req_pc_q;
      fetch_instr_o <= instr_sel;
    end
  end

  // a stale read must not move the PC past the jump target
  assign pc_step_o = ar_hs && !stale_q;

  assign ar_valid_o = ar_pend_q;
  assign ar_addr_o  = {req_pc_q[XLEN-1:3], 3'b000};  // dword aligned
  assign ar_prot_o  = AXI_PROT_FETCH;
  assign ar_size_o  = AXI_SIZE_DWORD;

  assign r_ready_o  = r_pend_q && stall_n_i;

  // a jump kills the word about to enter decode
  assign fetch_valid_o = valid_q && !jump_i;

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ps

module id_stage import rv_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n_i,

  // from fetch
  input  logic                     fetch_valid_i,
  input  logic [XLEN-1:0]          fetch_pc_i,
  input  logic [ILEN-1:0]          fetch_instr_i,

  // decoded view of the held instruction
  output logic [XLEN-1:0]          pc_o,
  output logic [ILEN-1:0]          instr_o,
  output logic [REG_IDX_WIDTH-1:0] rd_idx_o,
  output logic [REG_IDX_WIDTH-1:0] rs1_idx_o,
  output logic [REG_IDX_WIDTH-1:0] rs2_idx_o,
  output logic [XLEN-1:0]          imm_o,
  output logic                     instr_valid_o
);

  logic [XLEN-1:0] pc_q;
  logic [ILEN-1:0] instr_q;
  logic            valid_q;
  rv_instr_u       instr_w;
  logic            is_itype;

  // fetch/decode register, loads on every fetch pulse
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q    <= '0;
      instr_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_valid_i;
      if (fetch_valid_i) begin
        pc_q    <= fetch_pc_i;
        instr_q <= fetch_instr_i;
      end
    end
  end

  assign instr_w = instr_q;

  // register indices sit at the same place in every format
  assign rd_idx_o  = instr_w.r.rd;
  assign rs1_idx_o = instr_w.r.rs1;
  assign rs2_idx_o = instr_w.r.rs2;

  always_comb begin
    case (instr_w.i.opcode)
      OPC_OP_IMM,
      OPC_LOAD,
      OPC_JALR: is_itype = 1'b1;
      default:  is_itype = 1'b0;
    endcase
  end

  // sign extend imm[11:0] to XLEN
  assign imm_o = is_itype ? {{(XLEN-12){instr_w.i.imm[11]}}, instr_w.i.imm} : '0;

  assign pc_o          = pc_q;
  assign instr_o       = instr_q;
  assign instr_valid_o = valid_q;

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import axi_lite_pkg::*, rv_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      stall_n_i,
  input  logic                      jump_i,
  input  logic [XLEN-1:0]           jump_pc_i,

  // AXI-lite read, to memory
  input  logic                      ar_ready_i,
  output logic                      ar_valid_o,
  output logic [AXI_ADDR_WIDTH-1:0] ar_addr_o,
  output logic [2:0]                ar_prot_o,
  output logic [2:0]                ar_size_o,
  input  logic                      r_valid_i,
  output logic                      r_ready_o,
  input  logic [AXI_DATA_WIDTH-1:0] r_data_i,
  input  logic [AXI_RESP_WIDTH-1:0] r_resp_i,

  // decode results
  output logic [XLEN-1:0]           pc_o,
  output logic [ILEN-1:0]           instr_o,
  output logic [REG_IDX_WIDTH-1:0]  rd_idx_o,
  output logic [REG_IDX_WIDTH-1:0]  rs1_idx_o,
  output logic [REG_IDX_WIDTH-1:0]  rs2_idx_o,
  output logic [XLEN-1:0]           imm_o,
  output logic                      instr_valid_o
);

  logic [XLEN-1:0] pc_fetch;   // next address to request
  logic            pc_step;
  logic            if_valid;
  logic [XLEN-1:0] if_pc;
  logic [ILEN-1:0] if_instr;

  pc_gen u_pc_gen (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .jump_i     (jump_i),
    .jump_pc_i  (jump_pc_i),
    .pc_step_i  (pc_step),
    .fetch_pc_o (pc_fetch)
  );

  axi_fetch_master u_fetch (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .stall_n_i     (stall_n_i),
    .jump_i        (jump_i),
    .fetch_pc_i    (pc_fetch),
    .pc_step_o     (pc_step),
    .ar_ready_i    (ar_ready_i),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .ar_prot_o     (ar_prot_o),
    .ar_size_o     (ar_size_o),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .r_data_i      (r_data_i),
    .r_resp_i      (r_resp_i),
    .fetch_valid_o (if_valid),
    .fetch_pc_o    (if_pc),
    .fetch_instr_o (if_instr)
  );

  id_stage u_id (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .fetch_valid_i (if_valid),
    .fetch_pc_i    (if_pc),
    .fetch_instr_i (if_instr),
    .pc_o          (pc_o),
    .instr_o       (instr_o),
    .rd_idx_o      (rd_idx_o),
    .rs1_idx_o     (rs1_idx_o),
    .rs2_idx_o     (rs2_idx_o),
    .imm_o         (imm_o),
    .instr_valid_o (instr_valid_o)
  );

endmodule

// ==== mem_image.svh ====
// instruction memory contents as a function of the byte address
// low address bits pick the opcode so every I-type shows up often
function automatic logic [31:0] mem_word(input logic [63:0] addr);
  logic [31:0] h;
  logic [6:0]  opc;
  h = addr[31:0] * 32'h9e37_79b1;
  h = h ^ (h >> 15) ^ addr[63:32];
  case (addr[4:2])
    3'd0:    opc = 7'b0010011;  // op-imm
    3'd1:    opc = 7'b0000011;  // load
    3'd2:    opc = 7'b1100111;  // jalr
    3'd3:    opc = 7'b0110011;  // op
    3'd4:    opc = 7'b0100011;  // store
    3'd5:    opc = 7'b0110111;  // lui
    3'd6:    opc = 7'b0010011;
    default: opc = 7'b1100011;  // branch
  endcase
  return {h[31:7], opc};
endfunction

// ==== fetch_top_asserts.sv ====
`timescale 1ns/1ps

module fetch_top_asserts import axi_lite_pkg::*, rv_pkg::*; (
  input logic                      clk,
  input logic                      arst_n_i,
  input logic                      stall_n_i,
  input logic                      jump_i,
  input logic [XLEN-1:0]           jump_pc_i,
  input logic                      ar_ready_i,
  input logic                      ar_valid_o,
  input logic [AXI_ADDR_WIDTH-1:0] ar_addr_o,
  input logic [2:0]                ar_prot_o,
  input logic [2:0]                ar_size_o,
  input logic                      r_valid_i,
  input logic                      r_ready_o,
  input logic [XLEN-1:0]           pc_o,
  input logic [ILEN-1:0]           instr_o,
  input logic [REG_IDX_WIDTH-1:0]  rd_idx_o,
  input logic [REG_IDX_WIDTH-1:0]  rs1_idx_o,
  input logic [REG_IDX_WIDTH-1:0]  rs2_idx_o,
  input logic [XLEN-1:0]           imm_o,
  input logic                      instr_valid_o
);

  `include "mem_image.svh"

  int unsigned     err_cnt = 0;  // read by the testbench
  logic [XLEN-1:0] exp_pc;       // pc of the next instruction to be delivered
  logic            seen_ar;
  logic            i_type;
  logic [XLEN-1:0] exp_imm;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_pc  <= RESET_PC;
      seen_ar <= 1'b0;
    end else begin
      if (ar_valid_o) seen_ar <= 1'b1;
      if (jump_i) begin
        exp_pc <= jump_pc_i;
      end else if (instr_valid_o) begin
        exp_pc <= exp_pc + 64'd4;
      end
    end
  end

  assign i_type = (instr_o[6:0] == OPC_OP_IMM) || (instr_o[6:0] == OPC_LOAD) ||
                  (instr_o[6:0] == OPC_JALR);
  assign exp_imm = i_type ? {{52{instr_o[31]}}, instr_o[31:20]} : 64'd0;

  // quiet while in reset and on the first cycle out of it
  a_reset_quiet: assert property (@(posedge clk)
      (!arst_n_i || $rose(arst_n_i)) |-> !ar_valid_o && !r_ready_o && !instr_valid_o)
    else begin err_cnt++; $error("Error %0t: outputs active around reset", $time); end

  a_first_addr: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_o && !seen_ar |-> ar_addr_o == RESET_PC)
    else begin err_cnt++; $error("Error %0t: first address %h", $time, ar_addr_o); end

  a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else begin err_cnt++; $error("Error %0t: AR dropped or changed before ready", $time); end

  a_ar_attr: assert property (@(posedge clk) disable iff (!arst_n_i)
      ar_valid_o |-> ar_addr_o[2:0] == 3'b000 && ar_prot_o == AXI_PROT_FETCH &&
                     ar_size_o == AXI_SIZE_DWORD)
    else begin err_cnt++; $error("Error %0t: bad AR attributes at %h", $time, ar_addr_o); end

  // covers both sequential stepping and the jump redirect
  a_pc_seq: assert property (@(posedge clk) disable iff (!arst_n_i)
      instr_valid_o |-> pc_o == exp_pc)
    else begin err_cnt++; $error("Error %0t: pc_o %h, expected %h", $time, pc_o, exp_pc); end

  a_instr: assert property (@(posedge clk) disable iff (!arst_n_i)
      instr_valid_o |-> instr_o == mem_word(pc_o))
    else begin err_cnt++; $error("Error %0t: instr_o %h at pc %h", $time, instr_o, pc_o); end

  a_regs: assert property (@(posedge clk) disable iff (!arst_n_i)
      instr_valid_o |-> rd_idx_o == instr_o[11:7] && rs1_idx_o == instr_o[19:15] &&
                        rs2_idx_o == instr_o[24:20])
    else begin err_cnt++; $error("Error %0t: register index decode of %h", $time, instr_o); end

  a_imm: assert property (@(posedge clk) disable iff (!arst_n_i)
      instr_valid_o |-> imm_o == exp_imm)
    else begin err_cnt++; $error("Error %0t: imm_o %h, expected %h", $time, imm_o, exp_imm); end

  a_stall_r: assert property (@(posedge clk) disable iff (!arst_n_i)
      !stall_n_i |-> !r_ready_o)
    else begin err_cnt++; $error("Error %0t: r_ready_o high during stall", $time); end

  // low for three samples, pipeline drained
  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      !stall_n_i && !$past(stall_n_i) && !$past(stall_n_i, 2) |->
      !instr_valid_o && $stable(pc_o) && $stable(instr_o) && $stable(imm_o))
    else begin err_cnt++; $error("Error %0t: decode outputs moved during stall", $time); end

endmodule

bind fetch_top fetch_top_asserts u_asserts (.*);

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top import axi_lite_pkg::*, rv_pkg::*; ();

  `include "mem_image.svh"

  localparam int unsigned WAIT_LIMIT = 2000;  // cycles per wait loop

  logic                      clk;
  logic                      arst_n_i;
  logic                      stall_n_i;
  logic                      jump_i;
  logic [XLEN-1:0]           jump_pc_i;
  logic                      ar_ready_i;
  logic                      ar_valid_o;
  logic [AXI_ADDR_WIDTH-1:0] ar_addr_o;
  logic [2:0]                ar_prot_o;
  logic [2:0]                ar_size_o;
  logic                      r_valid_i;
  logic                      r_ready_o;
  logic [AXI_DATA_WIDTH-1:0] r_data_i;
  logic [AXI_RESP_WIDTH-1:0] r_resp_i;
  logic [XLEN-1:0]           pc_o;
  logic [ILEN-1:0]           instr_o;
  logic [REG_IDX_WIDTH-1:0]  rd_idx_o;
  logic [REG_IDX_WIDTH-1:0]  rs1_idx_o;
  logic [REG_IDX_WIDTH-1:0]  rs2_idx_o;
  logic [XLEN-1:0]           imm_o;
  logic                      instr_valid_o;

  bit          timed_out;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned err_base;

  fetch_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // memory slave, random ready on AR and random latency on R
  task automatic serve_reads();
    logic [63:0] addr;
    int unsigned cnt;
    int unsigned lat;
    forever begin
      cnt = 0;
      forever begin
        @(posedge clk);
        if (ar_valid_o && ar_ready_i) break;
        ar_ready_i <= ($urandom % 3) != 0;
        cnt++;
        if (cnt > WAIT_LIMIT) begin
          $display("responder: no read request for %0d cycles", WAIT_LIMIT);
          timed_out = 1'b1;
          return;
        end
      end
      addr = ar_addr_o;
      ar_ready_i <= 1'b0;
      lat = $urandom % 4;
      repeat (lat) @(posedge clk);
      r_valid_i <= 1'b1;
      r_data_i  <= {mem_word(addr + 64'd4), mem_word(addr)};
      cnt = 0;
      forever begin
        @(posedge clk);
        if (r_valid_i && r_ready_o) break;
        cnt++;
        if (cnt > WAIT_LIMIT) begin
          $display("responder: read data at %h never accepted", addr);
          timed_out = 1'b1;
          return;
        end
      end
      r_valid_i <= 1'b0;
      r_data_i  <= '0;
    end
  endtask

  task automatic wait_instrs(input int unsigned n);
    int unsigned seen;
    int unsigned cnt;
    seen = 0;
    cnt  = 0;
    while (seen < n && !timed_out) begin
      @(posedge clk);
      if (instr_valid_o) seen++;
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("no instruction delivered, got %0d of %0d", seen, n);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_first_ar();
    int unsigned cnt;
    cnt = 0;
    while (!ar_valid_o && !timed_out) begin
      @(posedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("no read request after reset");
        timed_out = 1'b1;
      end
    end
  endtask

  // waits until a read is in its data phase
  task automatic wait_outstanding();
    int unsigned cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("no outstanding read seen");
        timed_out = 1'b1;
      end
    end while (!r_ready_o && !timed_out);
  endtask

  task automatic send_jump(input logic [XLEN-1:0] target);
    jump_i    <= 1'b1;
    jump_pc_i <= target;
    @(posedge clk);
    jump_i    <= 1'b0;
  endtask

  function automatic logic [XLEN-1:0] pick_target();
    return 64'h8000_1000 + 64'(($urandom % 256) * 4);
  endfunction

  task automatic start_test();
    err_base = u_dut.u_asserts.err_cnt;
  endtask

  task automatic finish_test(input string name);
    int unsigned errs;
    errs = u_dut.u_asserts.err_cnt - err_base;
    tests_run++;
    if (errs != 0 || timed_out) begin
      tests_failed++;
      $display("test %s: FAIL, %0d assertion errors", name, errs);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    void'($urandom(32'h1022_9db6));
    timed_out    = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    err_base     = 0;
    arst_n_i     = 1'b0;
    stall_n_i    = 1'b1;
    jump_i       = 1'b0;
    jump_pc_i    = '0;
    ar_ready_i   = 1'b0;
    r_valid_i    = 1'b0;
    r_data_i     = '0;
    r_resp_i     = '0;

    fork
      serve_reads();
    join_none

    start_test();
    repeat (4) @(posedge clk);
    arst_n_i <= 1'b1;
    wait_first_ar();
    finish_test("reset");

    if (!timed_out) begin
      start_test();
      wait_instrs(16);
      finish_test("sequential");
    end

    if (!timed_out) begin
      start_test();
      wait_instrs(1);
      stall_n_i <= 1'b0;
      repeat (20) @(posedge clk);
      stall_n_i <= 1'b1;
      wait_instrs(4);
      finish_test("stall");
    end

    if (!timed_out) begin
      start_test();
      wait_instrs(1);
      send_jump(64'h8000_0404);  // upper half of a dword
      wait_instrs(6);
      finish_test("jump");
    end

    if (!timed_out) begin
      start_test();
      wait_outstanding();
      send_jump(pick_target());
      wait_instrs(3);
      wait_first_ar();
      send_jump(pick_target());  // while AR is pending
      wait_instrs(3);
      finish_test("jump_in_flight");
    end

    if (!timed_out) begin
      start_test();
      for (int k = 0; k < 6; k++) begin
        repeat ($urandom % 6) @(posedge clk);
        send_jump(pick_target());
        wait_instrs(2);
      end
      finish_test("random_jumps");
    end

    repeat (4) @(posedge clk);
    $display("tests %0d, failed %0d, assertion errors %0d, timeout %0d",
             tests_run, tests_failed, u_dut.u_asserts.err_cnt, timed_out);
    if (tests_failed == 0 && !timed_out && u_dut.u_asserts.err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== fetch_top.f ====
+incdir+.
axi_lite_pkg.sv
rv_pkg.sv
pc_gen.sv
axi_fetch_master.sv
id_stage.sv
fetch_top.sv
fetch_top_asserts.sv
tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  - files:
      - axi_lite_pkg.sv
      - rv_pkg.sv
      - pc_gen.sv
      - axi_fetch_master.sv
      - id_stage.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fetch_top_asserts.sv
      - tb_fetch_top.sv
